// ==== rtl/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder import xbar_pkg::*; (
  input  logic [ADDR_W-1:0] addr_i,
  output logic [TGT_W-1:0]  tgt_o
);

  // Walk down so the lowest matching output wins
  always_comb begin
    tgt_o = TGT_W'(NUM_OUT); // No range hit, route to decode error
    for (int j = NUM_OUT - 1; j >= 0; j--) begin
      if ((addr_i & OUT_MASK[j]) == OUT_BASE[j]) begin
        tgt_o = TGT_W'(j);
      end
    end
  end

endmodule

// ==== rtl/axil_xbar.sv ====
`timescale 1ns/1ps

module axil_xbar import xbar_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // Manager side
  input  logic [NUM_IN-1:0]                 in_awvalid_i,
  output logic [NUM_IN-1:0]                 in_awready_o,
  input  logic [NUM_IN-1:0][ADDR_W-1:0]     in_awaddr_i,
  input  logic [NUM_IN-1:0][2:0]            in_awprot_i,
  input  logic [NUM_IN-1:0]                 in_wvalid_i,
  output logic [NUM_IN-1:0]                 in_wready_o,
  input  logic [NUM_IN-1:0][DATA_W-1:0]     in_wdata_i,
  input  logic [NUM_IN-1:0][STRB_W-1:0]     in_wstrb_i,
  output logic [NUM_IN-1:0]                 in_bvalid_o,
  input  logic [NUM_IN-1:0]                 in_bready_i,
  output logic [NUM_IN-1:0][1:0]            in_bresp_o,
  input  logic [NUM_IN-1:0]                 in_arvalid_i,
  output logic [NUM_IN-1:0]                 in_arready_o,
  input  logic [NUM_IN-1:0][ADDR_W-1:0]     in_araddr_i,
  input  logic [NUM_IN-1:0][2:0]            in_arprot_i,
  output logic [NUM_IN-1:0]                 in_rvalid_o,
  input  logic [NUM_IN-1:0]                 in_rready_i,
  output logic [NUM_IN-1:0][DATA_W-1:0]     in_rdata_o,
  output logic [NUM_IN-1:0][1:0]            in_rresp_o,
  // Subordinate side
  output logic [NUM_OUT-1:0]                out_awvalid_o,
  input  logic [NUM_OUT-1:0]                out_awready_i,
  output logic [NUM_OUT-1:0][ADDR_W-1:0]    out_awaddr_o,
  output logic [NUM_OUT-1:0][2:0]           out_awprot_o,
  output logic [NUM_OUT-1:0]                out_wvalid_o,
  input  logic [NUM_OUT-1:0]                out_wready_i,
  output logic [NUM_OUT-1:0][DATA_W-1:0]    out_wdata_o,
  output logic [NUM_OUT-1:0][STRB_W-1:0]    out_wstrb_o,
  input  logic [NUM_OUT-1:0]                out_bvalid_i,
  output logic [NUM_OUT-1:0]                out_bready_o,
  input  logic [NUM_OUT-1:0][1:0]           out_bresp_i,
  output logic [NUM_OUT-1:0]                out_arvalid_o,
  input  logic [NUM_OUT-1:0]                out_arready_i,
  output logic [NUM_OUT-1:0][ADDR_W-1:0]    out_araddr_o,
  output logic [NUM_OUT-1:0][2:0]           out_arprot_o,
  input  logic [NUM_OUT-1:0]                out_rvalid_i,
  output logic [NUM_OUT-1:0]                out_rready_o,
  input  logic [NUM_OUT-1:0][DATA_W-1:0]    out_rdata_i,
  input  logic [NUM_OUT-1:0][1:0]           out_rresp_i
);

  logic [NUM_IN-1:0][TGT_W-1:0] aw_tgt;
  logic [NUM_IN-1:0][TGT_W-1:0] ar_tgt;
  logic [NUM_OUT:0][IN_W-1:0]   aw_sel;
  logic [NUM_OUT:0][IN_W-1:0]   ar_sel;
  logic [NUM_OUT:0]             aw_busy;
  logic [NUM_OUT:0]             ar_busy;
  logic [NUM_OUT:0]             aw_pend;
  logic [NUM_OUT:0]             w_pend;
  logic [NUM_OUT:0]             ar_pend;
  logic [NUM_IN-1:0][TGT_W-1:0] w_tgt;
  logic [NUM_IN-1:0][TGT_W-1:0] r_tgt;
  logic [NUM_IN-1:0]            w_act;
  logic [NUM_IN-1:0]            r_act;
  logic [NUM_OUT:0]             aw_done;
  logic [NUM_OUT:0]             w_done;
  logic [NUM_OUT:0]             ar_done;
  logic [NUM_IN-1:0]            b_done;
  logic [NUM_IN-1:0]            r_done;

  // Target side handshakes, index NUM_OUT is the decode-error responder
  logic [NUM_OUT:0]             tgt_awvalid;
  logic [NUM_OUT:0]             tgt_awready;
  logic [NUM_OUT:0]             tgt_wvalid;
  logic [NUM_OUT:0]             tgt_wready;
  logic [NUM_OUT:0]             tgt_bvalid;
  logic [NUM_OUT:0]             tgt_bready;
  logic [NUM_OUT:0][1:0]        tgt_bresp;
  logic [NUM_OUT:0]             tgt_arvalid;
  logic [NUM_OUT:0]             tgt_arready;
  logic [NUM_OUT:0]             tgt_rvalid;
  logic [NUM_OUT:0]             tgt_rready;
  rdata_pl_t [NUM_OUT:0]        tgt_r_pl;

  addr_pl_t [NUM_IN-1:0]        in_aw_pl;
  addr_pl_t [NUM_IN-1:0]        in_ar_pl;
  wdata_pl_t [NUM_IN-1:0]       in_w_pl;
  rdata_pl_t [NUM_IN-1:0]       in_r_pl;
  addr_pl_t [NUM_OUT-1:0]       out_aw_pl;
  addr_pl_t [NUM_OUT-1:0]       out_ar_pl;
  wdata_pl_t [NUM_OUT-1:0]      out_w_pl;

  for (genvar i = 0; i < NUM_IN; i++) begin : gen_in
    addr_decoder u_aw_dec (.addr_i(in_awaddr_i[i]), .tgt_o(aw_tgt[i]));
    addr_decoder u_ar_dec (.addr_i(in_araddr_i[i]), .tgt_o(ar_tgt[i]));

    assign in_aw_pl[i] = '{addr: in_awaddr_i[i], prot: in_awprot_i[i]};
    assign in_ar_pl[i] = '{addr: in_araddr_i[i], prot: in_arprot_i[i]};
    assign in_w_pl[i]  = '{data: in_wdata_i[i], strb: in_wstrb_i[i]};

    // Readies and responses only from the routed target
    assign in_awready_o[i] = w_act[i] & aw_pend[w_tgt[i]] & tgt_awready[w_tgt[i]];
    assign in_wready_o[i]  = w_act[i] & w_pend[w_tgt[i]] & tgt_wready[w_tgt[i]];
    assign in_bvalid_o[i]  = w_act[i] & tgt_bvalid[w_tgt[i]];
    assign in_bresp_o[i]   = tgt_bresp[w_tgt[i]];
    assign in_arready_o[i] = r_act[i] & ar_pend[r_tgt[i]] & tgt_arready[r_tgt[i]];
    assign in_rvalid_o[i]  = r_act[i] & tgt_rvalid[r_tgt[i]];

    chan_mux #(.payload_t(rdata_pl_t), .N_SEL(NUM_OUT + 1)) u_r_mux (
      .sel_i (r_tgt[i]),
      .pl_i  (tgt_r_pl),
      .pl_o  (in_r_pl[i])
    );
    assign in_rdata_o[i] = in_r_pl[i].data;
    assign in_rresp_o[i] = in_r_pl[i].resp;

    assign b_done[i] = in_bvalid_o[i] & in_bready_i[i];
    assign r_done[i] = in_rvalid_o[i] & in_rready_i[i];
  end

  for (genvar t = 0; t <= NUM_OUT; t++) begin : gen_tgt
    // Valids reach a target only from its owner
    assign tgt_awvalid[t] = aw_busy[t] & aw_pend[t] & in_awvalid_i[aw_sel[t]];
    assign tgt_wvalid[t]  = aw_busy[t] & w_pend[t] & in_wvalid_i[aw_sel[t]];
    assign tgt_bready[t]  = aw_busy[t] & in_bready_i[aw_sel[t]];
    assign tgt_arvalid[t] = ar_busy[t] & ar_pend[t] & in_arvalid_i[ar_sel[t]];
    assign tgt_rready[t]  = ar_busy[t] & in_rready_i[ar_sel[t]];

    assign aw_done[t] = tgt_awvalid[t] & tgt_awready[t];
    assign w_done[t]  = tgt_wvalid[t] & tgt_wready[t];
    assign ar_done[t] = tgt_arvalid[t] & tgt_arready[t];
  end

  for (genvar j = 0; j < NUM_OUT; j++) begin : gen_out
    chan_mux #(.payload_t(addr_pl_t), .N_SEL(NUM_IN)) u_aw_mux (
      .sel_i (aw_sel[j]),
      .pl_i  (in_aw_pl),
      .pl_o  (out_aw_pl[j])
    );
    chan_mux #(.payload_t(wdata_pl_t), .N_SEL(NUM_IN)) u_w_mux (
      .sel_i (aw_sel[j]),
      .pl_i  (in_w_pl),
      .pl_o  (out_w_pl[j])
    );
    chan_mux #(.payload_t(addr_pl_t), .N_SEL(NUM_IN)) u_ar_mux (
      .sel_i (ar_sel[j]),
      .pl_i  (in_ar_pl),
      .pl_o  (out_ar_pl[j])
    );

    assign out_awvalid_o[j] = tgt_awvalid[j];
    assign out_awaddr_o[j]  = out_aw_pl[j].addr;
    assign out_awprot_o[j]  = out_aw_pl[j].prot;
    assign out_wvalid_o[j]  = tgt_wvalid[j];
    assign out_wdata_o[j]   = out_w_pl[j].data;
    assign out_wstrb_o[j]   = out_w_pl[j].strb;
    assign out_bready_o[j]  = tgt_bready[j];
    assign out_arvalid_o[j] = tgt_arvalid[j];
    assign out_araddr_o[j]  = out_ar_pl[j].addr;
    assign out_arprot_o[j]  = out_ar_pl[j].prot;
    assign out_rready_o[j]  = tgt_rready[j];

    assign tgt_awready[j] = out_awready_i[j];
    assign tgt_wready[j]  = out_wready_i[j];
    assign tgt_bvalid[j]  = out_bvalid_i[j];
    assign tgt_bresp[j]   = out_bresp_i[j];
    assign tgt_arready[j] = out_arready_i[j];
    assign tgt_rvalid[j]  = out_rvalid_i[j];
    assign tgt_r_pl[j]    = '{data: out_rdata_i[j], resp: out_rresp_i[j]};
  end

  // Decode-error target answers with fixed codes
  assign tgt_bresp[NUM_OUT] = RESP_DECERR;
  assign tgt_r_pl[NUM_OUT]  = '{data: '0, resp: RESP_DECERR};

  decerr_responder u_decerr (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awvalid_i (tgt_awvalid[NUM_OUT]),
    .awready_o (tgt_awready[NUM_OUT]),
    .wvalid_i  (tgt_wvalid[NUM_OUT]),
    .wready_o  (tgt_wready[NUM_OUT]),
    .bvalid_o  (tgt_bvalid[NUM_OUT]),
    .bready_i  (tgt_bready[NUM_OUT]),
    .arvalid_i (tgt_arvalid[NUM_OUT]),
    .arready_o (tgt_arready[NUM_OUT]),
    .rvalid_o  (tgt_rvalid[NUM_OUT]),
    .rready_i  (tgt_rready[NUM_OUT])
  );

  xbar_route_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .aw_req_i      (in_awvalid_i & in_wvalid_i), // AW and W travel together
    .ar_req_i      (in_arvalid_i),
    .aw_tgt_i      (aw_tgt),
    .ar_tgt_i      (ar_tgt),
    .aw_done_i     (aw_done),
    .w_done_i      (w_done),
    .ar_done_i     (ar_done),
    .b_done_i      (b_done),
    .r_done_i      (r_done),
    .out_aw_sel_o  (aw_sel),
    .out_ar_sel_o  (ar_sel),
    .out_aw_busy_o (aw_busy),
    .out_ar_busy_o (ar_busy),
    .out_aw_pend_o (aw_pend),
    .out_w_pend_o  (w_pend),
    .out_ar_pend_o (ar_pend),
    .in_w_tgt_o    (w_tgt),
    .in_r_tgt_o    (r_tgt),
    .in_w_act_o    (w_act),
    .in_r_act_o    (r_act)
  );

endmodule

// ==== rtl/chan_mux.sv ====
`timescale 1ns/1ps

module chan_mux #(
  parameter type payload_t = logic,
  parameter int  N_SEL     = 2
) (
  input  logic [$clog2(N_SEL)-1:0] sel_i,
  input  payload_t [N_SEL-1:0]     pl_i,
  output payload_t                 pl_o
);

  always_comb begin
    pl_o = pl_i[0]; // Out of range index falls back to source 0
    for (int k = 1; k < N_SEL; k++) begin
      if (sel_i == $clog2(N_SEL)'(k)) begin
        pl_o = pl_i[k];
      end
    end
  end

endmodule

// ==== rtl/decerr_responder.sv ====
`timescale 1ns/1ps

module decerr_responder (
  input  logic clk_i,
  input  logic rst_i,
  input  logic awvalid_i,
  output logic awready_o,
  input  logic wvalid_i,
  output logic wready_o,
  output logic bvalid_o,
  input  logic bready_i,
  input  logic arvalid_i,
  output logic arready_o,
  output logic rvalid_o,
  input  logic rready_i
);

  logic aw_got; // AW accepted, waiting for W
  logic w_got;  // W accepted, waiting for AW
  logic aw_seen;
  logic w_seen;

  // No new beats while a response is outstanding
  assign awready_o = ~aw_got & ~bvalid_o;
  assign wready_o  = ~w_got & ~bvalid_o;
  assign arready_o = ~rvalid_o;

  assign aw_seen = aw_got | (awvalid_i & awready_o);
  assign w_seen  = w_got | (wvalid_i & wready_o);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      if (bvalid_o) begin
        if (bready_i) bvalid_o <= 1'b0;
      end else if (aw_seen && w_seen) begin
        // Both halves in, answer next cycle
        bvalid_o <= 1'b1;
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
      end else begin
        aw_got <= aw_seen;
        w_got  <= w_seen;
      end

      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
      end else if (arvalid_i && arready_o) begin
        rvalid_o <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/xbar_pkg.sv ====
package xbar_pkg;

  // Port counts
  localparam int NUM_IN  = 2;
  localparam int NUM_OUT = 2;
  localparam int TGT_W   = 2; // Covers outputs plus the decode-error target
  localparam int IN_W    = 1;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Address map, one base/mask pair per output
  localparam logic [NUM_OUT-1:0][ADDR_W-1:0] OUT_BASE = {16'h4000, 16'h0000};
  localparam logic [NUM_OUT-1:0][ADDR_W-1:0] OUT_MASK = {16'hC000, 16'hC000};

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // Address channel payload, AW and AR
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } addr_pl_t;

  // Write data payload
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } wdata_pl_t;

  // Read data payload
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } rdata_pl_t;

endpackage

// ==== rtl/xbar_route_ctrl.sv ====
`timescale 1ns/1ps

module xbar_route_ctrl import xbar_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [NUM_IN-1:0]             aw_req_i,
  input  logic [NUM_IN-1:0]             ar_req_i,
  input  logic [NUM_IN-1:0][TGT_W-1:0]  aw_tgt_i,
  input  logic [NUM_IN-1:0][TGT_W-1:0]  ar_tgt_i,
  input  logic [NUM_OUT:0]              aw_done_i,
  input  logic [NUM_OUT:0]              w_done_i,
  input  logic [NUM_OUT:0]              ar_done_i,
  input  logic [NUM_IN-1:0]             b_done_i,
  input  logic [NUM_IN-1:0]             r_done_i,
  output logic [NUM_OUT:0][IN_W-1:0]    out_aw_sel_o,
  output logic [NUM_OUT:0][IN_W-1:0]    out_ar_sel_o,
  output logic [NUM_OUT:0]              out_aw_busy_o,
  output logic [NUM_OUT:0]              out_ar_busy_o,
  output logic [NUM_OUT:0]              out_aw_pend_o,
  output logic [NUM_OUT:0]              out_w_pend_o,
  output logic [NUM_OUT:0]              out_ar_pend_o,
  output logic [NUM_IN-1:0][TGT_W-1:0]  in_w_tgt_o,
  output logic [NUM_IN-1:0][TGT_W-1:0]  in_r_tgt_o,
  output logic [NUM_IN-1:0]             in_w_act_o,
  output logic [NUM_IN-1:0]             in_r_act_o
);

  logic [NUM_OUT:0][IN_W-1:0]   w_rr_q;     // Last write winner per target
  logic [NUM_OUT:0][IN_W-1:0]   r_rr_q;     // Last read winner per target
  logic [NUM_OUT:0][NUM_IN-1:0] w_req;
  logic [NUM_OUT:0][NUM_IN-1:0] r_req;
  logic [NUM_OUT:0]             w_gnt;
  logic [NUM_OUT:0]             r_gnt;
  logic [NUM_OUT:0][IN_W-1:0]   w_gnt_idx;
  logic [NUM_OUT:0][IN_W-1:0]   r_gnt_idx;
  logic [NUM_IN-1:0]            in_w_gnt;
  logic [NUM_IN-1:0]            in_r_gnt;

  // First requester after the previous winner
  function automatic logic [IN_W-1:0] rr_pick(input logic [NUM_IN-1:0] req,
                                              input logic [IN_W-1:0]   last);
    logic [IN_W-1:0] pick;
    int              idx;
    pick = last;
    for (int k = NUM_IN; k >= 1; k--) begin
      idx = (int'(last) + k) % NUM_IN;
      if (req[idx]) pick = IN_W'(idx);
    end
    return pick;
  endfunction

  for (genvar t = 0; t <= NUM_OUT; t++) begin : gen_tgt
    for (genvar i = 0; i < NUM_IN; i++) begin : gen_req
      // Only idle inputs compete
      assign w_req[t][i] = aw_req_i[i] & ~in_w_act_o[i] & (aw_tgt_i[i] == TGT_W'(t));
      assign r_req[t][i] = ar_req_i[i] & ~in_r_act_o[i] & (ar_tgt_i[i] == TGT_W'(t));
    end
    assign w_gnt[t]     = ~out_aw_busy_o[t] & (|w_req[t]);
    assign r_gnt[t]     = ~out_ar_busy_o[t] & (|r_req[t]);
    assign w_gnt_idx[t] = rr_pick(w_req[t], w_rr_q[t]);
    assign r_gnt_idx[t] = rr_pick(r_req[t], r_rr_q[t]);
  end

  // Fold target grants back onto the inputs
  always_comb begin
    in_w_gnt = '0;
    in_r_gnt = '0;
    for (int t = 0; t <= NUM_OUT; t++) begin
      for (int i = 0; i < NUM_IN; i++) begin
        if (w_gnt[t] && w_gnt_idx[t] == IN_W'(i)) in_w_gnt[i] = 1'b1;
        if (r_gnt[t] && r_gnt_idx[t] == IN_W'(i)) in_r_gnt[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_rr_q        <= '0;
      r_rr_q        <= '0;
      out_aw_sel_o  <= '0;
      out_ar_sel_o  <= '0;
      out_aw_busy_o <= '0;
      out_ar_busy_o <= '0;
      out_aw_pend_o <= '0;
      out_w_pend_o  <= '0;
      out_ar_pend_o <= '0;
      in_w_tgt_o    <= '0;
      in_r_tgt_o    <= '0;
      in_w_act_o    <= '0;
      in_r_act_o    <= '0;
    end else begin
      for (int t = 0; t <= NUM_OUT; t++) begin
        if (aw_done_i[t]) out_aw_pend_o[t] <= 1'b0;
        if (w_done_i[t])  out_w_pend_o[t]  <= 1'b0;
        if (ar_done_i[t]) out_ar_pend_o[t] <= 1'b0;
        // Ownership ends with the response at the owning input
        if (out_aw_busy_o[t] && b_done_i[out_aw_sel_o[t]]) out_aw_busy_o[t] <= 1'b0;
        if (out_ar_busy_o[t] && r_done_i[out_ar_sel_o[t]]) out_ar_busy_o[t] <= 1'b0;

        if (w_gnt[t]) begin
          out_aw_busy_o[t] <= 1'b1;
          out_aw_sel_o[t]  <= w_gnt_idx[t];
          w_rr_q[t]        <= w_gnt_idx[t];
          out_aw_pend_o[t] <= 1'b1;
          out_w_pend_o[t]  <= 1'b1;
        end
        if (r_gnt[t]) begin
          out_ar_busy_o[t] <= 1'b1;
          out_ar_sel_o[t]  <= r_gnt_idx[t];
          r_rr_q[t]        <= r_gnt_idx[t];
          out_ar_pend_o[t] <= 1'b1;
        end
      end

      for (int i = 0; i < NUM_IN; i++) begin
        if (b_done_i[i]) in_w_act_o[i] <= 1'b0;
        if (r_done_i[i]) in_r_act_o[i] <= 1'b0;
        if (in_w_gnt[i]) begin
          in_w_act_o[i] <= 1'b1;
          in_w_tgt_o[i] <= aw_tgt_i[i];
        end
        if (in_r_gnt[i]) begin
          in_r_act_o[i] <= 1'b1;
          in_r_tgt_o[i] <= ar_tgt_i[i];
        end
      end
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f sources.f --top-module tb_axil_xbar -o sim_axil_xbar

./obj_dir/sim_axil_xbar +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
  exit 0
fi
exit 1

// ==== sources.f ====
rtl/xbar_pkg.sv
rtl/addr_decoder.sv
rtl/chan_mux.sv
rtl/decerr_responder.sv
rtl/xbar_route_ctrl.sv
rtl/axil_xbar.sv
verification/axil_xbar_assertions.sv
verification/tb_axil_xbar.sv

// ==== verification/axil_xbar_assertions.sv ====
`timescale 1ns/1ps

module axil_xbar_assertions import xbar_pkg::*; (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic [NUM_IN-1:0]              in_awvalid_i,
  input logic [NUM_IN-1:0]              in_awready_o,
  input logic [NUM_IN-1:0][ADDR_W-1:0]  in_awaddr_i,
  input logic [NUM_IN-1:0][2:0]         in_awprot_i,
  input logic [NUM_IN-1:0]              in_wvalid_i,
  input logic [NUM_IN-1:0]              in_wready_o,
  input logic [NUM_IN-1:0]              in_arvalid_i,
  input logic [NUM_IN-1:0]              in_arready_o,
  input logic [NUM_IN-1:0][ADDR_W-1:0]  in_araddr_i,
  input logic [NUM_IN-1:0][2:0]         in_arprot_i,
  input logic [NUM_IN-1:0]              in_bvalid_o,
  input logic [NUM_IN-1:0]              in_rvalid_o,
  input logic [NUM_OUT-1:0]             out_awvalid_o,
  input logic [NUM_OUT-1:0]             out_awready_i,
  input logic [NUM_OUT-1:0][ADDR_W-1:0] out_awaddr_o,
  input logic [NUM_OUT-1:0][2:0]        out_awprot_o,
  input logic [NUM_OUT-1:0]             out_wvalid_o,
  input logic [NUM_OUT-1:0]             out_wready_i,
  input logic [NUM_OUT-1:0][DATA_W-1:0] out_wdata_o,
  input logic [NUM_OUT-1:0]             out_arvalid_o,
  input logic [NUM_OUT-1:0]             out_arready_i,
  input logic [NUM_OUT-1:0][ADDR_W-1:0] out_araddr_o,
  input logic [NUM_OUT-1:0][2:0]        out_arprot_o
);

  int   fail_cnt = 0;
  logic seen_any; // Some input raised a valid since reset

  function automatic logic hits(input logic [ADDR_W-1:0] a, input int j);
    return (a & OUT_MASK[j]) == OUT_BASE[j];
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) seen_any <= 1'b0;
    else if ((|in_awvalid_i) || (|in_wvalid_i) || (|in_arvalid_i)) seen_any <= 1'b1;
  end

  // Quiet bus until the first request
  idle_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
    !seen_any |-> (out_awvalid_o == '0 && out_wvalid_o == '0 && out_arvalid_o == '0 &&
                   in_awready_o == '0 && in_wready_o == '0 && in_arready_o == '0 &&
                   in_bvalid_o == '0 && in_rvalid_o == '0))
    else begin
      $error("Output valid or ready high before any request");
      fail_cnt = fail_cnt + 1;
    end

  for (genvar j = 0; j < NUM_OUT; j++) begin : gen_out
    aw_route: assert property (@(posedge clk_i) disable iff (rst_i)
      out_awvalid_o[j] |-> hits(out_awaddr_o[j], j) &&
        ((out_awaddr_o[j] == in_awaddr_i[0] && out_awprot_o[j] == in_awprot_i[0]) ||
         (out_awaddr_o[j] == in_awaddr_i[1] && out_awprot_o[j] == in_awprot_i[1])))
      else begin
        $error("AW address or prot at output %0d is misrouted", j);
        fail_cnt = fail_cnt + 1;
      end
    ar_route: assert property (@(posedge clk_i) disable iff (rst_i)
      out_arvalid_o[j] |-> hits(out_araddr_o[j], j) &&
        ((out_araddr_o[j] == in_araddr_i[0] && out_arprot_o[j] == in_arprot_i[0]) ||
         (out_araddr_o[j] == in_araddr_i[1] && out_arprot_o[j] == in_arprot_i[1])))
      else begin
        $error("AR address or prot at output %0d is misrouted", j);
        fail_cnt = fail_cnt + 1;
      end
    // Stalled payloads hold still
    aw_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      out_awvalid_o[j] && !out_awready_i[j] |=> out_awvalid_o[j] && $stable(out_awaddr_o[j]))
      else begin
        $error("AW at output %0d changed while stalled", j);
        fail_cnt = fail_cnt + 1;
      end
    w_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      out_wvalid_o[j] && !out_wready_i[j] |=> out_wvalid_o[j] && $stable(out_wdata_o[j]))
      else begin
        $error("W at output %0d changed while stalled", j);
        fail_cnt = fail_cnt + 1;
      end
    ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      out_arvalid_o[j] && !out_arready_i[j] |=> out_arvalid_o[j] && $stable(out_araddr_o[j]))
      else begin
        $error("AR at output %0d changed while stalled", j);
        fail_cnt = fail_cnt + 1;
      end
    // Never two inputs served by one output in the same cycle
    one_aw_owner: assert property (@(posedge clk_i) disable iff (rst_i)
      !(in_awvalid_i[0] && in_awready_o[0] && hits(in_awaddr_i[0], j) &&
        in_awvalid_i[1] && in_awready_o[1] && hits(in_awaddr_i[1], j)))
      else begin
        $error("Two AW owners at output %0d", j);
        fail_cnt = fail_cnt + 1;
      end
    one_ar_owner: assert property (@(posedge clk_i) disable iff (rst_i)
      !(in_arvalid_i[0] && in_arready_o[0] && hits(in_araddr_i[0], j) &&
        in_arvalid_i[1] && in_arready_o[1] && hits(in_araddr_i[1], j)))
      else begin
        $error("Two AR owners at output %0d", j);
        fail_cnt = fail_cnt + 1;
      end
  end

endmodule

// ==== verification/tb_axil_xbar.sv ====
`timescale 1ns/1ps

// Subordinate memory with random ready and response delays
module mem_model import xbar_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  output logic              bvalid_o,
  input  logic              bready_i,
  output logic [1:0]        bresp_o,
  input  logic              arvalid_i,
  output logic              arready_o,
  input  logic [ADDR_W-1:0] araddr_i,
  output logic              rvalid_o,
  input  logic              rready_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic [1:0]        rresp_o
);

  logic [DATA_W-1:0] mem [logic [ADDR_W-3:0]];

  task automatic idle();
    repeat ($urandom_range(0, 3)) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] word;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    bresp_o   = RESP_OKAY;
    forever begin
      @(negedge clk_i);
      if (!rst_i && awvalid_i) begin
        @(posedge clk_i);
        #1;
        idle();
        awready_o = 1'b1;
        @(negedge clk_i); // Valid is held, so this edge transfers
        addr = awaddr_i;
        @(posedge clk_i);
        #1;
        awready_o = 1'b0;
        idle();
        wready_o = 1'b1;
        do @(negedge clk_i); while (!wvalid_i);
        word = mem.exists(addr[ADDR_W-1:2]) ? mem[addr[ADDR_W-1:2]] : '0;
        for (int b = 0; b < STRB_W; b++) begin
          if (wstrb_i[b]) word[b*8 +: 8] = wdata_i[b*8 +: 8];
        end
        mem[addr[ADDR_W-1:2]] = word;
        @(posedge clk_i);
        #1;
        wready_o = 1'b0;
        idle();
        bvalid_o = 1'b1;
        do @(negedge clk_i); while (!bready_i);
        @(posedge clk_i);
        #1;
        bvalid_o = 1'b0;
      end
    end
  end

  initial begin
    logic [ADDR_W-1:0] addr;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rresp_o   = RESP_OKAY;
    forever begin
      @(negedge clk_i);
      if (!rst_i && arvalid_i) begin
        @(posedge clk_i);
        #1;
        idle();
        arready_o = 1'b1;
        @(negedge clk_i);
        addr = araddr_i;
        @(posedge clk_i);
        #1;
        arready_o = 1'b0;
        idle();
        rdata_o  = mem.exists(addr[ADDR_W-1:2]) ? mem[addr[ADDR_W-1:2]] : '0;
        rvalid_o = 1'b1;
        do @(negedge clk_i); while (!rready_i);
        @(posedge clk_i);
        #1;
        rvalid_o = 1'b0;
      end
    end
  end

endmodule

module tb_axil_xbar import xbar_pkg::*; ();

  localparam int NUM_TXN = 37;
  localparam int TIMEOUT_CYC = NUM_TXN * 40 + 200;

  logic clk_i;
  logic rst_i;
  logic [NUM_IN-1:0]              in_awvalid_i, in_awready_o, in_wvalid_i, in_wready_o;
  logic [NUM_IN-1:0][ADDR_W-1:0]  in_awaddr_i, in_araddr_i;
  logic [NUM_IN-1:0][2:0]         in_awprot_i, in_arprot_i;
  logic [NUM_IN-1:0][DATA_W-1:0]  in_wdata_i, in_rdata_o;
  logic [NUM_IN-1:0][STRB_W-1:0]  in_wstrb_i;
  logic [NUM_IN-1:0]              in_bvalid_o, in_bready_i, in_arvalid_i, in_arready_o;
  logic [NUM_IN-1:0]              in_rvalid_o, in_rready_i;
  logic [NUM_IN-1:0][1:0]         in_bresp_o, in_rresp_o;
  logic [NUM_OUT-1:0]             out_awvalid_o, out_awready_i, out_wvalid_o, out_wready_i;
  logic [NUM_OUT-1:0][ADDR_W-1:0] out_awaddr_o, out_araddr_o;
  logic [NUM_OUT-1:0][2:0]        out_awprot_o, out_arprot_o;
  logic [NUM_OUT-1:0][DATA_W-1:0] out_wdata_o, out_rdata_i;
  logic [NUM_OUT-1:0][STRB_W-1:0] out_wstrb_o;
  logic [NUM_OUT-1:0]             out_bvalid_i, out_bready_o, out_arvalid_o, out_arready_i;
  logic [NUM_OUT-1:0]             out_rvalid_i, out_rready_o;
  logic [NUM_OUT-1:0][1:0]        out_bresp_i, out_rresp_i;

  logic [DATA_W-1:0] ref_mem [logic [ADDR_W-3:0]]; // Expected contents by word address
  int                done_cnt [NUM_IN];

  axil_xbar u_axil_xbar (.*);

  bind axil_xbar axil_xbar_assertions u_assert (.*);

  for (genvar j = 0; j < NUM_OUT; j++) begin : gen_mem
    mem_model u_mem (
      .clk_i, .rst_i,
      .awvalid_i (out_awvalid_o[j]), .awready_o (out_awready_i[j]), .awaddr_i (out_awaddr_o[j]),
      .wvalid_i  (out_wvalid_o[j]),  .wready_o  (out_wready_i[j]),  .wdata_i  (out_wdata_o[j]),
      .wstrb_i   (out_wstrb_o[j]),
      .bvalid_o  (out_bvalid_i[j]),  .bready_i  (out_bready_o[j]),  .bresp_o  (out_bresp_i[j]),
      .arvalid_i (out_arvalid_o[j]), .arready_o (out_arready_i[j]), .araddr_i (out_araddr_o[j]),
      .rvalid_o  (out_rvalid_i[j]),  .rready_i  (out_rready_o[j]),  .rdata_o  (out_rdata_i[j]),
      .rresp_o   (out_rresp_i[j])
    );
  end

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      report_failure("Data check failed");
    end
  endtask

  function automatic logic [31:0] ref_word(input logic [ADDR_W-1:0] addr);
    if (ref_mem.exists(addr[ADDR_W-1:2])) return ref_mem[addr[ADDR_W-1:2]];
    return '0;
  endfunction

  // Byte lanes with strobe set take the new data
  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                        input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic do_write(input int m, input logic [15:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    logic       aw_ok, w_ok, aw_hs, w_hs, b_hs;
    logic [1:0] exp_resp;
    aw_ok = 1'b0;
    w_ok  = 1'b0;
    b_hs  = 1'b0;
    exp_resp = (addr >= 16'h8000) ? RESP_DECERR : RESP_OKAY;
    in_awaddr_i[m]  = addr;
    in_awprot_i[m]  = 3'(m);
    in_wdata_i[m]   = data;
    in_wstrb_i[m]   = strb;
    in_awvalid_i[m] = 1'b1;
    in_wvalid_i[m]  = 1'b1;
    while (!(aw_ok && w_ok)) begin
      @(negedge clk_i);
      aw_hs = in_awvalid_i[m] && in_awready_o[m];
      w_hs  = in_wvalid_i[m] && in_wready_o[m];
      @(posedge clk_i);
      #1;
      if (aw_hs) begin
        in_awvalid_i[m] = 1'b0;
        aw_ok = 1'b1;
      end
      if (w_hs) begin
        in_wvalid_i[m] = 1'b0;
        w_ok = 1'b1;
      end
    end
    repeat ($urandom_range(0, 2)) begin
      @(posedge clk_i);
      #1;
    end
    in_bready_i[m] = 1'b1;
    while (!b_hs) begin
      @(negedge clk_i);
      b_hs = in_bvalid_o[m];
      if (b_hs) check_val("in_bresp_o", 32'(in_bresp_o[m]), 32'(exp_resp));
      @(posedge clk_i);
      #1;
    end
    in_bready_i[m] = 1'b0;
    if (exp_resp == RESP_OKAY) ref_mem[addr[15:2]] = merge(ref_word(addr), data, strb);
    done_cnt[m]++;
  endtask

  task automatic do_read(input int m, input logic [15:0] addr);
    logic       ar_hs, r_hs;
    logic [1:0] exp_resp;
    ar_hs = 1'b0;
    r_hs  = 1'b0;
    exp_resp = (addr >= 16'h8000) ? RESP_DECERR : RESP_OKAY;
    in_araddr_i[m]  = addr;
    in_arprot_i[m]  = 3'(m);
    in_arvalid_i[m] = 1'b1;
    while (!ar_hs) begin
      @(negedge clk_i);
      ar_hs = in_arready_o[m];
      @(posedge clk_i);
      #1;
    end
    in_arvalid_i[m] = 1'b0;
    repeat ($urandom_range(0, 2)) begin
      @(posedge clk_i);
      #1;
    end
    in_rready_i[m] = 1'b1;
    while (!r_hs) begin
      @(negedge clk_i);
      r_hs = in_rvalid_o[m];
      if (r_hs) begin
        check_val("in_rresp_o", 32'(in_rresp_o[m]), 32'(exp_resp));
        // Reference word of unmapped space is zero like DECERR data
        check_val("in_rdata_o", in_rdata_o[m], ref_word(addr));
      end
      @(posedge clk_i);
      #1;
    end
    in_rready_i[m] = 1'b0;
    done_cnt[m]++;
  endtask

  // Four writes then four reads to output 1
  task automatic contend(input int m);
    logic [15:0] base;
    base = 16'h4800 + 16'(m * 16'h100);
    for (int k = 0; k < 4; k++) do_write(m, base + 16'(k * 4), $urandom, 4'hF);
    for (int k = 0; k < 4; k++) do_read(m, base + 16'(k * 4));
  endtask

  always @(negedge clk_i) begin
    if (u_axil_xbar.u_assert.fail_cnt != 0) report_failure("A protocol assertion failed");
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    report_failure("Watchdog timeout, a transaction never completed");
  end

  initial begin
    logic [15:0] addr;
    void'($urandom(32'ha509_1e59));
    rst_i        = 1'b1;
    in_awvalid_i = '0;
    in_awaddr_i  = '0;
    in_awprot_i  = '0;
    in_wvalid_i  = '0;
    in_wdata_i   = '0;
    in_wstrb_i   = '0;
    in_bready_i  = '0;
    in_arvalid_i = '0;
    in_araddr_i  = '0;
    in_arprot_i  = '0;
    in_rready_i  = '0;
    done_cnt[0] = 0;
    done_cnt[1] = 0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    repeat (3) begin
      @(posedge clk_i);
      #1;
    end

    // Each input to each output with full then partial strobe
    for (int m = 0; m < NUM_IN; m++) begin
      for (int j = 0; j < NUM_OUT; j++) begin
        addr = OUT_BASE[j] + 16'(m * 16'h100) + 16'h0010;
        do_write(m, addr, $urandom, 4'hF);
        do_write(m, addr, $urandom, 4'b0101);
        do_read(m, addr);
      end
    end

    // Unmapped space
    do_write(0, 16'h8000, 32'hDEAD_BEEF, 4'hF);
    do_read(0, 16'h8004);
    do_write(1, 16'hC010, 32'h1234_5678, 4'h3);
    do_read(1, 16'hC010);

    // Both inputs fight for output 1
    fork
      contend(0);
      contend(1);
    join
    if (done_cnt[0] != 16 || done_cnt[1] != 16) begin
      report_failure("Completion count mismatch after contention");
    end

    // Write and read in parallel from one input
    fork
      do_write(0, 16'h0040, 32'hA5A5_0F0F, 4'hF);
      do_read(0, 16'h4010);
    join
    fork
      do_write(1, 16'h4044, 32'h5A5A_F0F0, 4'hC);
      do_read(1, 16'h9000);
    join
    do_read(0, 16'h0040);

    repeat (5) @(posedge clk_i);
    if (u_axil_xbar.u_assert.fail_cnt != 0 || done_cnt[0] + done_cnt[1] != NUM_TXN) begin
      report_failure("Assertion failure or lost transaction at end of run");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule
